// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    localparam int num_log_regs = 32;

    typedef logic [4:0] log_reg_t;
    typedef logic [7:0] phys_reg_t;
    typedef logic [4:0] page_t;
    typedef logic [6:0] opcode_t;

    // One full alias table where entry i holds the mapping of logical register i
    typedef phys_reg_t [num_log_regs-1:0] rat_image_t;

    // RISC-V major opcodes that matter to the operand classes
    typedef enum logic [6:0] {
        op_none   = 7'b0000000,
        op_load   = 7'b0000011,
        op_op_imm = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_op     = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_class_t;

    localparam phys_reg_t phys_src_none  = 8'hFE;  // Source operand not used
    localparam phys_reg_t phys_dest_none = 8'hFF;  // No destination written

    typedef struct packed {
        logic uses_rs1;
        logic uses_rs2;
        logic writes_rd;
    } operand_use_t;

    typedef struct packed {
        log_reg_t rs1;
        log_reg_t rs2;
        log_reg_t rd;
        opcode_t  opcode;
        logic     valid;
    } rename_req_t;

    typedef struct packed {
        phys_reg_t phys_rs1;
        phys_reg_t phys_rs2;
        phys_reg_t phys_rd;
        phys_reg_t old_phys_rd;
        logic      valid;
    } rename_result_t;

endpackage

// ==== rtl/operand_class_decode.sv ====
module operand_class_decode (
    input  rename_pkg::opcode_t      opcode,
    output rename_pkg::operand_use_t operand_use
);
    import rename_pkg::*;

    always_comb begin
        operand_use.uses_rs1  = 1'b1;
        operand_use.uses_rs2  = 1'b1;
        operand_use.writes_rd = 1'b1;

        // Source usage
        case (opcode)
            op_jalr,
            op_load,
            op_op_imm: begin
                operand_use.uses_rs2 = 1'b0;  // Immediate takes the place of rs2
            end
            op_lui,
            op_auipc,
            op_jal: begin
                operand_use.uses_rs1 = 1'b0;
                operand_use.uses_rs2 = 1'b0;
            end
            default: begin
                operand_use.uses_rs1 = 1'b1;
            end
        endcase

        // Branches and stores have no rd field and opcode zero is a bubble
        case (opcode)
            op_branch,
            op_store,
            op_none: begin
                operand_use.writes_rd = 1'b0;
            end
            default: begin
                operand_use.writes_rd = 1'b1;
            end
        endcase
    end

endmodule

// ==== rtl/rat_checkpoint_store.sv ====
module rat_checkpoint_store #(
    parameter int num_pages = 32
) (
    input  logic                   clk,
    input  logic                   save,
    input  rename_pkg::page_t      save_page,
    input  rename_pkg::rat_image_t save_image,
    input  rename_pkg::page_t      restore_page,
    output rename_pkg::rat_image_t restore_image
);
    import rename_pkg::*;

    // Each page holds a complete alias table image
    rat_image_t pages [num_pages];

    always_ff @(posedge clk) begin
        if (save) begin
            pages[save_page] <= save_image;
        end
    end

    // Combinational read so a restore can rename against the page in the same cycle
    assign restore_image = pages[restore_page];

    a_save_page_in_range: assert property (
        @(posedge clk) save |-> (32'(save_page) < num_pages)
    ) else $error("Checkpoint save to page %0d beyond %0d pages", save_page, num_pages);

endmodule

// ==== rtl/register_alias_table.sv ====
module register_alias_table (
    input  logic                       clk,
    input  logic                       reset,
    input  rename_pkg::rename_req_t    req,
    input  rename_pkg::operand_use_t   operand_use,
    input  logic                       flush,
    input  logic                       restore,
    input  rename_pkg::rat_image_t     restore_image,
    input  rename_pkg::phys_reg_t      alloc_reg,
    input  logic                       empty,
    output logic                       alloc_take,
    output logic                       stall,
    output rename_pkg::rat_image_t     save_image,
    output rename_pkg::rename_result_t result
);
    import rename_pkg::*;

    rat_image_t     rat_table;
    rat_image_t     base_map;
    rat_image_t     next_map;
    rename_result_t result_next;
    logic           needs_rd;
    logic           rename_en;
    logic           accept;

    // A restore replaces the live table before the lookup
    assign base_map = restore ? restore_image : rat_table;

    assign needs_rd = operand_use.writes_rd && (req.rd != '0);  // x0 never gets a register
    assign stall    = req.valid && needs_rd && empty;

    // Restore is checked first, so a flush in a restore cycle does not drop the request
    assign rename_en  = req.valid && (restore || !flush);
    assign accept     = rename_en && !stall;
    assign alloc_take = accept && needs_rd;

    assign save_image = rat_table;  // Image before this cycle's update

    always_comb begin
        result_next.valid = accept;

        if (operand_use.uses_rs1) begin
            result_next.phys_rs1 = base_map[req.rs1];
        end else begin
            result_next.phys_rs1 = phys_src_none;
        end

        if (operand_use.uses_rs2) begin
            result_next.phys_rs2 = base_map[req.rs2];
        end else begin
            result_next.phys_rs2 = phys_src_none;
        end

        if (needs_rd) begin
            result_next.phys_rd     = alloc_reg;
            result_next.old_phys_rd = base_map[req.rd];  // Returned to the free list at commit
        end else begin
            result_next.phys_rd     = phys_dest_none;
            result_next.old_phys_rd = alloc_reg;
        end

        next_map = base_map;
        if (alloc_take) begin
            next_map[req.rd] = alloc_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_log_regs; i++) begin
                rat_table[i] <= phys_reg_t'(i);  // Identity map
            end
            result <= '{
                phys_rs1:    phys_src_none,
                phys_rs2:    phys_src_none,
                phys_rd:     phys_dest_none,
                old_phys_rd: phys_dest_none,
                valid:       1'b0
            };
        end else begin
            rat_table <= next_map;
            result    <= result_next;
        end
    end

    // Holds across restores too, so every saved page must keep x0 on register 0
    a_x0_fixed: assert property (
        @(posedge clk) disable iff (reset) rat_table[0] == '0
    ) else $error("Alias table entry 0 remapped to %0d", rat_table[0]);

endmodule

// ==== rtl/free_list.sv ====
module free_list #(
    parameter int num_phys_regs = 128,
    parameter int num_pages     = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc_take,
    output rename_pkg::phys_reg_t alloc_reg,
    output logic                  empty,
    input  logic                  release_valid,
    input  rename_pkg::phys_reg_t release_reg,
    input  logic                  save,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore,
    input  rename_pkg::page_t     restore_page
);
    import rename_pkg::*;

    // The queue is deeper than the number of free registers, so head equal to tail
    // always means empty and the count can be rebuilt from the pointers
    localparam int depth    = num_phys_regs;
    localparam int num_free = num_phys_regs - num_log_regs;
    localparam int ptr_w    = $clog2(depth);
    localparam int count_w  = $clog2(depth + 1);

    typedef logic [ptr_w-1:0]   ptr_t;
    typedef logic [count_w-1:0] count_t;

    phys_reg_t queue [depth];
    ptr_t      saved_head [num_pages];
    ptr_t      head;
    ptr_t      tail;
    count_t    count;
    ptr_t      head_base;
    count_t    count_base;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Restore rewinds the head first and a pop in the same cycle works from there
    always_comb begin
        if (restore) begin
            head_base = saved_head[restore_page];
            if (tail >= head_base) begin
                count_base = count_t'(tail - head_base);
            end else begin
                count_base = count_t'(depth) - count_t'(head_base) + count_t'(tail);
            end
        end else begin
            head_base  = head;
            count_base = count;
        end
    end

    assign alloc_reg = queue[head_base];
    assign empty     = (count_base == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_free; i++) begin
                queue[i] <= phys_reg_t'(num_log_regs + i);  // Registers above the identity map
            end
        end else if (release_valid) begin
            queue[tail] <= release_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= ptr_t'(num_free);
            count <= count_t'(num_free);
        end else begin
            head  <= alloc_take ? ptr_inc(head_base) : head_base;
            tail  <= release_valid ? ptr_inc(tail) : tail;
            count <= count_base + count_t'(release_valid) - count_t'(alloc_take);
        end
    end

    always_ff @(posedge clk) begin
        if (save) begin
            saved_head[save_page] <= head;  // Head before this cycle's pop
        end
    end

    a_no_take_when_empty: assert property (
        @(posedge clk) disable iff (reset) alloc_take |-> !empty
    ) else $error("Register taken from an empty free list");

    // More free entries than registers outside the map means a double release
    a_count_bound: assert property (
        @(posedge clk) disable iff (reset) count <= count_t'(num_free)
    ) else $error("Free list count %0d above %0d", count, num_free);

endmodule

// ==== rtl/rename_stage.sv ====
module rename_stage #(
    parameter int num_phys_regs = 128,
    parameter int num_pages     = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  rename_pkg::rename_req_t    req,
    input  logic                       save,
    input  logic                       restore,
    input  logic                       flush,
    input  rename_pkg::page_t          save_page,
    input  rename_pkg::page_t          restore_page,
    input  logic                       release_valid,
    input  rename_pkg::phys_reg_t      release_reg,
    output rename_pkg::rename_result_t result,
    output logic                       stall
);
    import rename_pkg::*;

    operand_use_t op_use;
    rat_image_t   save_image;
    rat_image_t   restore_image;
    phys_reg_t    alloc_reg;
    logic         alloc_take;
    logic         empty;
    logic         save_en;

    // Restore wins over save, and a flushed cycle saves nothing
    assign save_en = save && !restore && !flush;

    operand_class_decode operand_class_decode_inst (
        .opcode      (req.opcode),
        .operand_use (op_use)
    );

    register_alias_table register_alias_table_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .operand_use   (op_use),
        .flush         (flush),
        .restore       (restore),
        .restore_image (restore_image),
        .alloc_reg     (alloc_reg),
        .empty         (empty),
        .alloc_take    (alloc_take),
        .stall         (stall),
        .save_image    (save_image),
        .result        (result)
    );

    rat_checkpoint_store #(
        .num_pages (num_pages)
    ) rat_checkpoint_store_inst (
        .clk           (clk),
        .save          (save_en),
        .save_page     (save_page),
        .save_image    (save_image),
        .restore_page  (restore_page),
        .restore_image (restore_image)
    );

    free_list #(
        .num_phys_regs (num_phys_regs),
        .num_pages     (num_pages)
    ) free_list_inst (
        .clk           (clk),
        .reset         (reset),
        .alloc_take    (alloc_take),
        .alloc_reg     (alloc_reg),
        .empty         (empty),
        .release_valid (release_valid),
        .release_reg   (release_reg),
        .save          (save_en),
        .save_page     (save_page),
        .restore       (restore),
        .restore_page  (restore_page)
    );

endmodule

// ==== testbench/rename_stage_tb.sv ====
module rename_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rename_pkg::*;

    localparam int num_phys_regs = 128;
    localparam int num_pages     = 32;
    localparam int num_free      = num_phys_regs - 32;
    localparam int total_cycles  = 520;
    localparam int timeout_ns    = total_cycles * 4 + 400;

    logic           clk;
    logic           reset;
    rename_req_t    req;
    logic           save;
    logic           restore;
    logic           flush;
    page_t          save_page;
    page_t          restore_page;
    logic           release_valid;
    phys_reg_t      release_reg;
    rename_result_t result;
    logic           stall;

    // Reference model of table, pages and free queue
    rat_image_t     m_table;
    rat_image_t     m_pages [num_pages];
    logic           m_page_valid [num_pages];
    int             m_saved_head [num_pages];
    phys_reg_t      m_queue [num_phys_regs];
    logic           m_known [num_phys_regs];  // Slot written since reset
    int             m_head;
    int             m_tail;
    int             m_count;
    rename_result_t exp_result;
    logic           exp_old_known;
    logic           exp_stall;

    int             errors;
    int             tests_run;
    int             tests_failed;
    logic [31:0]    rng_state;

    rename_stage #(
        .num_phys_regs (num_phys_regs),
        .num_pages     (num_pages)
    ) rename_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .save          (save),
        .restore       (restore),
        .flush         (flush),
        .save_page     (save_page),
        .restore_page  (restore_page),
        .release_valid (release_valid),
        .release_reg   (release_reg),
        .result        (result),
        .stall         (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int ring_dist(int tail_ptr, int head_ptr);
        return (tail_ptr - head_ptr + num_phys_regs) % num_phys_regs;
    endfunction

    // Operand usage straight from the RISC-V opcode map
    function automatic operand_use_t expected_use(opcode_t op);
        operand_use_t u;
        u.uses_rs1  = !(op inside {op_lui, op_auipc, op_jal});
        u.uses_rs2  = !(op inside {op_lui, op_auipc, op_jal, op_jalr, op_load, op_op_imm});
        u.writes_rd = !(op inside {op_branch, op_store, op_none});
        return u;
    endfunction

    function automatic opcode_t pick_opcode(logic [3:0] idx);
        case (idx)
            4'd0:    return op_load;
            4'd1:    return op_op_imm;
            4'd2:    return op_auipc;
            4'd3:    return op_store;
            4'd4:    return op_lui;
            4'd5:    return op_branch;
            4'd6:    return op_jalr;
            4'd7:    return op_jal;
            4'd8:    return op_none;
            4'd9:    return 7'b1110011;  // SYSTEM falls in the both-sources class
            default: return op_op;
        endcase
    endfunction

    // A release must not push any reachable free count past the free register total
    function automatic logic release_allowed();
        if (m_count >= num_free) begin
            return 1'b0;
        end
        for (int p = 0; p < num_pages; p++) begin
            if (m_page_valid[p] && ring_dist(m_tail, m_saved_head[p]) >= num_free) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin : reference_model
        rat_image_t     base;
        rat_image_t     next_table;
        operand_use_t   u;
        rename_result_t r;
        int             hb;
        int             cb;
        logic           needs_rd;
        logic           accept;
        logic           take;

        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                m_table[i] <= phys_reg_t'(i);
            end
            for (int i = 0; i < num_phys_regs; i++) begin
                m_queue[i] <= (i < num_free) ? phys_reg_t'(32 + i) : '0;
                m_known[i] <= (i < num_free);
            end
            for (int p = 0; p < num_pages; p++) begin
                m_page_valid[p] <= 1'b0;
            end
            m_head        <= 0;
            m_tail        <= num_free;
            m_count       <= num_free;
            exp_old_known <= 1'b1;
            exp_result    <= '{
                phys_rs1:    phys_src_none,
                phys_rs2:    phys_src_none,
                phys_rd:     phys_dest_none,
                old_phys_rd: phys_dest_none,
                valid:       1'b0
            };
        end else begin
            base     = restore ? m_pages[restore_page] : m_table;
            hb       = restore ? m_saved_head[restore_page] : m_head;
            cb       = restore ? ring_dist(m_tail, hb) : m_count;
            u        = expected_use(req.opcode);
            needs_rd = u.writes_rd && (req.rd != '0);
            accept   = req.valid && (restore || !flush) && !(needs_rd && cb == 0);
            take     = accept && needs_rd;

            r.valid       = accept;
            r.phys_rs1    = u.uses_rs1 ? base[req.rs1] : phys_src_none;
            r.phys_rs2    = u.uses_rs2 ? base[req.rs2] : phys_src_none;
            r.phys_rd     = needs_rd ? m_queue[hb] : phys_dest_none;
            r.old_phys_rd = needs_rd ? base[req.rd] : m_queue[hb];
            exp_result    <= r;
            exp_old_known <= needs_rd || m_known[hb];

            next_table = base;
            if (take) begin
                next_table[req.rd] = m_queue[hb];
            end
            m_table <= next_table;
            m_head  <= take ? (hb + 1) % num_phys_regs : hb;
            m_count <= cb + int'(release_valid) - int'(take);
            if (release_valid) begin
                m_queue[m_tail] <= release_reg;
                m_known[m_tail] <= 1'b1;
                m_tail          <= (m_tail + 1) % num_phys_regs;
            end
            if (save && !restore && !flush) begin
                m_pages[save_page]      <= m_table;
                m_saved_head[save_page] <= m_head;
                m_page_valid[save_page] <= 1'b1;
            end
        end
    end

    always_comb begin
        operand_use_t u;
        int           cb;
        u = expected_use(req.opcode);
        if (restore) begin
            cb = ring_dist(m_tail, m_saved_head[restore_page]);
        end else begin
            cb = m_count;
        end
        exp_stall = req.valid && u.writes_rd && (req.rd != '0) && (cb == 0);
    end

    task automatic report_mismatch(string name, logic [31:0] dut_value, logic [31:0] exp_value);
        errors++;
        $display("mismatch at %0t ns: %s dut=%0h expected=%0h", $time, name, dut_value, exp_value);
    endtask

    task automatic flag_failure(string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (reset)
        result.valid == exp_result.valid)
        else report_mismatch("result.valid", 32'(result.valid), 32'(exp_result.valid));
    a_rs1: assert property (@(posedge clk) disable iff (reset)
        exp_result.valid |-> result.phys_rs1 == exp_result.phys_rs1)
        else report_mismatch("result.phys_rs1", 32'(result.phys_rs1), 32'(exp_result.phys_rs1));
    a_rs2: assert property (@(posedge clk) disable iff (reset)
        exp_result.valid |-> result.phys_rs2 == exp_result.phys_rs2)
        else report_mismatch("result.phys_rs2", 32'(result.phys_rs2), 32'(exp_result.phys_rs2));
    a_rd: assert property (@(posedge clk) disable iff (reset)
        exp_result.valid |-> result.phys_rd == exp_result.phys_rd)
        else report_mismatch("result.phys_rd", 32'(result.phys_rd), 32'(exp_result.phys_rd));
    a_old_rd: assert property (@(posedge clk) disable iff (reset)
        (exp_result.valid && exp_old_known) |-> result.old_phys_rd == exp_result.old_phys_rd)
        else report_mismatch("result.old_phys_rd", 32'(result.old_phys_rd),
                             32'(exp_result.old_phys_rd));
    a_stall: assert property (@(posedge clk) disable iff (reset) stall == exp_stall)
        else report_mismatch("stall", 32'(stall), 32'(exp_stall));

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        req           = '0;
        save          = 1'b0;
        restore       = 1'b0;
        flush         = 1'b0;
        save_page     = '0;
        restore_page  = '0;
        release_valid = 1'b0;
        release_reg   = '0;
    endtask

    task automatic send(opcode_t op, log_reg_t rd, log_reg_t rs1, log_reg_t rs2);
        req.valid  = 1'b1;
        req.opcode = op;
        req.rd     = rd;
        req.rs1    = rs1;
        req.rs2    = rs2;
    endtask

    task automatic apply_reset();
        clear_inputs();
        reset = 1'b1;
        repeat (4) tick();
        reset = 1'b0;
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic rename_all_registers();
        apply_reset();
        assert (!result.valid && result.phys_rd == phys_dest_none)
            else flag_failure("result not in its reset state");
        assert (result.phys_rs1 == phys_src_none && result.phys_rs2 == phys_src_none)
            else flag_failure("source fields not marked unused after reset");
        for (int i = 1; i < 32; i++) begin
            clear_inputs();
            send(op_op, log_reg_t'(i), log_reg_t'(i), log_reg_t'(i + 1));
            tick();
        end
        clear_inputs();
        tick();
    endtask

    task automatic decode_each_class();
        apply_reset();
        for (int k = 0; k < 11; k++) begin
            clear_inputs();
            send(pick_opcode(4'(k)), 5, 6, 7);
            tick();
        end
        clear_inputs();
        send(op_op, 0, 3, 4);  // x0 destination takes nothing from the free list
        tick();
        send(op_jal, 0, 1, 2);
        tick();
        send(op_op, 9, 0, 5);
        tick();
        clear_inputs();
        tick();
    endtask

    task automatic save_and_restore();
        apply_reset();
        send(op_op, 1, 0, 0);
        tick();
        send(op_op, 2, 1, 0);
        tick();
        save      = 1'b1;
        save_page = 5;
        send(op_op, 3, 1, 2);
        tick();
        clear_inputs();
        save      = 1'b1;
        save_page = 6;
        send(op_op, 1, 2, 3);
        tick();
        save = 1'b0;
        send(op_load, 2, 1, 0);
        tick();
        send(op_op, 4, 1, 2);
        tick();
        clear_inputs();
        restore      = 1'b1;
        restore_page = 5;
        send(op_op, 3, 1, 2);
        tick();
        clear_inputs();
        send(op_op, 5, 3, 1);
        tick();
        // Restore beats both the save and the flush of the same cycle
        restore      = 1'b1;
        restore_page = 5;
        save         = 1'b1;
        save_page    = 6;
        flush        = 1'b1;
        send(op_op, 6, 3, 4);
        tick();
        clear_inputs();
        flush     = 1'b1;
        save      = 1'b1;
        save_page = 5;
        send(op_op, 7, 6, 0);
        tick();
        clear_inputs();
        send(op_op, 8, 7, 6);
        tick();
        // Both pages still hold the images from before the blocked saves
        restore      = 1'b1;
        restore_page = 6;
        send(op_op, 9, 5, 1);
        tick();
        restore_page = 5;
        send(op_op, 10, 6, 3);
        tick();
        clear_inputs();
        tick();
    endtask

    task automatic drive_random_traffic(int cycles);
        logic [31:0] r;
        int          p;
        apply_reset();
        for (int c = 0; c < cycles; c++) begin
            clear_inputs();
            r = lcg_next();
            send(pick_opcode(r[29:26]), r[25:21], r[20:16], r[15:11]);
            req.valid = (r[31:30] != 2'b00);
            r = lcg_next();
            if (r[31:29] == 3'b000) begin
                save      = 1'b1;
                save_page = r[28:24];
            end
            p = int'(r[19:15]);
            if (r[23:20] == 4'h0 && m_page_valid[p]) begin
                restore      = 1'b1;
                restore_page = page_t'(p);
            end
            flush = (r[14:11] == 4'h0);
            r = lcg_next();
            if (r[31:30] != 2'b00 && release_allowed()) begin
                release_valid = 1'b1;
                release_reg   = phys_reg_t'(32 + int'(r[29:16]) % num_free);
            end
            tick();
        end
        clear_inputs();
        tick();
    endtask

    task automatic exhaust_free_list();
        apply_reset();
        for (int i = 0; i < num_free; i++) begin
            clear_inputs();
            send(op_op, log_reg_t'((i % 31) + 1), 1, 2);
            tick();
        end
        clear_inputs();
        send(op_op, 9, 1, 2);
        #1;
        assert (stall) else flag_failure("stall stayed low with an empty free list");
        tick();
        clear_inputs();
        release_valid = 1'b1;
        release_reg   = 8'd77;
        tick();
        clear_inputs();
        send(op_op, 10, 9, 0);
        tick();
        assert (result.valid && result.phys_rd == 8'd77)
            else report_mismatch("result.phys_rd", 32'(result.phys_rd), 32'd77);
        clear_inputs();
        tick();
    endtask

    initial begin
        int mark;
        rng_state    = 32'h1341_5532;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        clear_inputs();

        mark = errors;
        rename_all_registers();
        finish_test("sequential rename", mark);
        mark = errors;
        decode_each_class();
        finish_test("operand classes", mark);
        mark = errors;
        save_and_restore();
        finish_test("checkpoint restore", mark);
        mark = errors;
        drive_random_traffic(300);
        finish_test("random traffic", mark);
        mark = errors;
        exhaust_free_list();
        finish_test("free list exhaustion", mark);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("error at %0t ns: watchdog expired before the tests finished", $time);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/rename_pkg.sv
rtl/operand_class_decode.sv
rtl/rat_checkpoint_store.sv
rtl/register_alias_table.sv
rtl/free_list.sv
rtl/rename_stage.sv
testbench/rename_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module rename_stage_tb -f files.f -o rename_sim

output=$(./obj_dir/rename_sim 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
